// File: logic/trace_pkg.sv
/*
 * Shared widths, vector types and constants of the retirement trace bridge
 * Trap word layout, NMI causes, halt hold count and interrupt bit map
 */

`default_nettype none

package trace_pkg;

   ////////////////////////////////////////////////////////////////////////
   // Vector types

   // Data word for PCs, instructions, CSR values and register data
   typedef logic [31:0] xlen_t;

   // Retirement sequence number
   typedef logic [63:0] order_t;

   // Trap word as reported by the retirement port
   typedef logic [13:0] trap_t;

   // Integer register index and one-hot writeback mask
   typedef logic [4:0]  reg_addr_t;
   typedef logic [31:0] reg_mask_t;

   // NMI status, bit 0 pending, bit 1 store (1) or load (0)
   typedef logic [1:0]  nmip_t;

   // Raw interrupt inputs and the compacted line vector
   typedef logic [31:0] irq_t;
   typedef logic [18:0] irq_lines_t;

   // NMI cause code handed to the reference model
   typedef logic [10:0] nmi_cause_t;

   // Halt request hold counter
   typedef logic [2:0]  halt_cnt_t;

   ////////////////////////////////////////////////////////////////////////
   // Trap word fields

   localparam int TRAP_BIT      = 0;
   localparam int EXC_BIT       = 1;
   localparam int EXC_CAUSE_LSB = 3;
   localparam int EXC_CAUSE_MSB = 8;

   // Exception cause field width follows from its bit positions
   localparam int EXC_CAUSE_W = EXC_CAUSE_MSB - EXC_CAUSE_LSB + 1;

   // Instruction fetch bus fault
   localparam logic [EXC_CAUSE_W-1:0] FETCH_FAULT_CAUSE = 6'd48;

   ////////////////////////////////////////////////////////////////////////
   // NMI causes

   localparam nmi_cause_t NMI_CAUSE_LOAD  = 11'd1024;
   localparam nmi_cause_t NMI_CAUSE_STORE = 11'd1025;

   // Bit positions inside nmip_t
   localparam int NMIP_PEND_BIT  = 0;
   localparam int NMIP_STORE_BIT = 1;

   ////////////////////////////////////////////////////////////////////////
   // Debug halt request

   // Cycles the halt request stays up after the core drops it
   localparam halt_cnt_t HALT_HOLD_CYCLES = 3'd5;

   ////////////////////////////////////////////////////////////////////////
   // Interrupt line map

   // Machine software, timer and external interrupt inputs
   localparam int IRQ_MSW_BIT    = 3;
   localparam int IRQ_MTIMER_BIT = 7;
   localparam int IRQ_MEXT_BIT   = 11;

   // First of the sixteen local interrupt lines, they run to bit 31
   localparam int IRQ_LOCAL_LSB  = 16;

endpackage

`default_nettype wire

// File: logic/csr_merge.sv
/*
 * One CSR observation merge
 * Combines masked read and write data and tracks the pending writeback flag
 */

`default_nettype none

module csr_merge (
   input  wire logic            rvvi,
   input  wire logic            arst_n_i,
   input  wire logic            rvfi_valid_i,
   input  wire trace_pkg::xlen_t rdata_i,
   input  wire trace_pkg::xlen_t wdata_i,
   input  wire trace_pkg::xlen_t rmask_i,
   input  wire trace_pkg::xlen_t wmask_i,
   output trace_pkg::xlen_t      value_o,
   output logic                  wb_o
);

   trace_pkg::xlen_t merged;
   trace_pkg::xlen_t value_q;
   logic             wb_q;

   // Written bits win, read bits fill in where nothing was written
   assign merged = (wdata_i & wmask_i) | (rdata_i & ~wmask_i & rmask_i);

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         value_q <= '0;
      end else begin
         value_q <= merged;
      end
   end

   // New value pending until the next retirement consumes it
   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_q <= 1'b0;
      end else if (merged != value_q) begin
         wb_q <= 1'b1;
      end else if (rvfi_valid_i) begin
         wb_q <= 1'b0;
      end
   end

   assign value_o = value_q;
   assign wb_o    = wb_q;

   // A writeback flag never comes up without the value moving
   wb_rise_needs_change : assert property (
      @(posedge rvvi) disable iff (!arst_n_i)
      (!wb_q ##1 wb_q) |-> (value_q != $past(value_q))
   );

endmodule

`default_nettype wire

// File: logic/retire_capture.sv
/*
 * Retirement record register stage
 * Also decodes the integer register writeback into a one-hot mask
 */

`default_nettype none

module retire_capture (
   input  wire logic                 rvvi,
   input  wire logic                 arst_n_i,
   input  wire logic                 rvfi_valid_i,
   input  wire trace_pkg::order_t    rvfi_order_i,
   input  wire trace_pkg::xlen_t     rvfi_insn_i,
   input  wire trace_pkg::xlen_t     rvfi_pc_rdata_i,
   input  wire trace_pkg::xlen_t     rvfi_pc_wdata_i,
   input  wire trace_pkg::trap_t     rvfi_trap_i,
   input  wire trace_pkg::reg_addr_t rd_addr_i,
   input  wire trace_pkg::xlen_t     rd_wdata_i,
   output logic                      valid_o,
   output trace_pkg::order_t         order_o,
   output trace_pkg::xlen_t          insn_o,
   output trace_pkg::xlen_t          pc_rdata_o,
   output trace_pkg::xlen_t          pc_wdata_o,
   output trace_pkg::trap_t          trap_o,
   output trace_pkg::reg_mask_t      rd_mask_o,
   output trace_pkg::xlen_t          rd_wdata_o
);

   trace_pkg::reg_mask_t rd_mask;

   // x0 is hardwired, so it never shows up as a writeback
   assign rd_mask = (rvfi_valid_i && (rd_addr_i != '0)) ?
                    (trace_pkg::reg_mask_t'(1) << rd_addr_i) : '0;

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_o    <= 1'b0;
         order_o    <= '0;
         insn_o     <= '0;
         pc_rdata_o <= '0;
         pc_wdata_o <= '0;
         trap_o     <= '0;
         rd_mask_o  <= '0;
         rd_wdata_o <= '0;
      end else begin
         valid_o    <= rvfi_valid_i;
         order_o    <= rvfi_order_i;
         insn_o     <= rvfi_insn_i;
         pc_rdata_o <= rvfi_pc_rdata_i;
         pc_wdata_o <= rvfi_pc_wdata_i;
         trap_o     <= rvfi_trap_i;
         rd_mask_o  <= rd_mask;
         rd_wdata_o <= rd_wdata_i;
      end
   end

   // At most one register written per retirement
   rd_mask_onehot : assert property (
      @(posedge rvvi) disable iff (!arst_n_i)
      $onehot0(rd_mask_o)
   );

endmodule

`default_nettype wire

// File: logic/halt_stretch.sv
/*
 * Debug halt request stretcher
 * Holds the request after it falls and strobes on every level change
 */

`default_nettype none

module halt_stretch (
   input  wire logic rvvi,
   input  wire logic arst_n_i,
   input  wire logic debug_req_i,
   output logic      halt_o,
   output logic      halt_push_o
);

   trace_pkg::halt_cnt_t cnt_q;
   logic                 halt_d;
   logic                 halt_q;
   logic                 push_q;

   // Reload while requested, then run down to zero
   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= '0;
      end else if (debug_req_i) begin
         cnt_q <= trace_pkg::HALT_HOLD_CYCLES;
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // Counter is looked at before this edge's update
   assign halt_d = debug_req_i | (cnt_q != '0);

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         halt_q <= 1'b0;
         push_q <= 1'b0;
      end else begin
         halt_q <= halt_d;
         push_q <= halt_d ^ halt_q;
      end
   end

   assign halt_o      = halt_q;
   assign halt_push_o = push_q;

   cnt_in_range : assert property (
      @(posedge rvvi) disable iff (!arst_n_i)
      cnt_q <= trace_pkg::HALT_HOLD_CYCLES
   );

endmodule

`default_nettype wire

// File: logic/nmi_fault_tracker.sv
/*
 * NMI and instruction fetch bus fault tracking
 * Sampled on retirement only, with level change strobes for the model
 */

`default_nettype none

module nmi_fault_tracker (
   input  wire logic             rvvi,
   input  wire logic             arst_n_i,
   input  wire logic             rvfi_valid_i,
   input  wire trace_pkg::trap_t rvfi_trap_i,
   input  wire trace_pkg::nmip_t rvfi_nmip_i,
   output logic                  nmi_o,
   output trace_pkg::nmi_cause_t nmi_cause_o,
   output logic                  nmi_push_o,
   output logic                  ifault_o,
   output logic                  ifault_push_o
);

   logic                  nmi_pend;
   trace_pkg::nmi_cause_t nmi_cause;
   logic                  fetch_fault;

   ////////////////////////////////////////////////////////////////////////
   // Decode of the retirement fields

   assign nmi_pend  = rvfi_nmip_i[trace_pkg::NMIP_PEND_BIT];
   assign nmi_cause = rvfi_nmip_i[trace_pkg::NMIP_STORE_BIT] ?
                      trace_pkg::NMI_CAUSE_STORE : trace_pkg::NMI_CAUSE_LOAD;

   // Trap that is an exception with the fetch fault cause
   assign fetch_fault = rvfi_trap_i[trace_pkg::TRAP_BIT] &&
                        rvfi_trap_i[trace_pkg::EXC_BIT] &&
                        (rvfi_trap_i[trace_pkg::EXC_CAUSE_MSB:trace_pkg::EXC_CAUSE_LSB] ==
                         trace_pkg::FETCH_FAULT_CAUSE);

   ////////////////////////////////////////////////////////////////////////
   // Levels and strobes

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         nmi_o         <= 1'b0;
         nmi_cause_o   <= '0;
         nmi_push_o    <= 1'b0;
         ifault_o      <= 1'b0;
         ifault_push_o <= 1'b0;
      end else if (rvfi_valid_i) begin
         nmi_o         <= nmi_pend;
         nmi_push_o    <= nmi_pend ^ nmi_o;
         ifault_o      <= fetch_fault;
         ifault_push_o <= fetch_fault ^ ifault_o;
         // Cause is kept from the last pending NMI
         if (nmi_pend) begin
            nmi_cause_o <= nmi_cause;
         end
      end else begin
         nmi_push_o    <= 1'b0;
         ifault_push_o <= 1'b0;
      end
   end

   push_after_retire : assert property (
      @(posedge rvvi) disable iff (!arst_n_i)
      (nmi_push_o || ifault_push_o) |-> $past(rvfi_valid_i)
   );

endmodule

`default_nettype wire

// File: logic/irq_sampler.sv
/*
 * Interrupt input sampler
 * Compacts the machine and local lines and strobes when the inputs move
 */

`default_nettype none

module irq_sampler (
   input  wire logic            rvvi,
   input  wire logic            arst_n_i,
   input  wire trace_pkg::irq_t irq_i,
   output trace_pkg::irq_lines_t irq_lines_o,
   output logic                  irq_push_o
);

   trace_pkg::irq_t irq_q;
   logic            push_q;

   // Previous sample, the whole word counts for change detection
   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         irq_q  <= '0;
         push_q <= 1'b0;
      end else begin
         irq_q  <= irq_i;
         push_q <= (irq_i != irq_q);
      end
   end

   // Software, timer, external, then local lines 16 to 31
   assign irq_lines_o = {irq_q[31:trace_pkg::IRQ_LOCAL_LSB],
                         irq_q[trace_pkg::IRQ_MEXT_BIT],
                         irq_q[trace_pkg::IRQ_MTIMER_BIT],
                         irq_q[trace_pkg::IRQ_MSW_BIT]};

   assign irq_push_o = push_q;

endmodule

`default_nettype wire

// File: logic/rvfi_event_bridge.sv
/*
 * Retirement trace event bridge top level
 * Record capture, three CSR merges, halt stretch, NMI and interrupt tracking
 */

`default_nettype none

module rvfi_event_bridge (
   input  wire logic                 rvvi,
   input  wire logic                 arst_n_i,
   // Retirement port
   input  wire logic                 rvfi_valid_i,
   input  wire trace_pkg::order_t    rvfi_order_i,
   input  wire trace_pkg::xlen_t     rvfi_insn_i,
   input  wire trace_pkg::trap_t     rvfi_trap_i,
   input  wire trace_pkg::xlen_t     rvfi_pc_rdata_i,
   input  wire trace_pkg::xlen_t     rvfi_pc_wdata_i,
   input  wire trace_pkg::nmip_t     rvfi_nmip_i,
   input  wire trace_pkg::reg_addr_t rd_addr_i,
   input  wire trace_pkg::xlen_t     rd_wdata_i,
   // CSR observations
   input  wire trace_pkg::xlen_t     mstatus_rdata_i,
   input  wire trace_pkg::xlen_t     mstatus_wdata_i,
   input  wire trace_pkg::xlen_t     mstatus_rmask_i,
   input  wire trace_pkg::xlen_t     mstatus_wmask_i,
   input  wire trace_pkg::xlen_t     mepc_rdata_i,
   input  wire trace_pkg::xlen_t     mepc_wdata_i,
   input  wire trace_pkg::xlen_t     mepc_rmask_i,
   input  wire trace_pkg::xlen_t     mepc_wmask_i,
   input  wire trace_pkg::xlen_t     mcause_rdata_i,
   input  wire trace_pkg::xlen_t     mcause_wdata_i,
   input  wire trace_pkg::xlen_t     mcause_rmask_i,
   input  wire trace_pkg::xlen_t     mcause_wmask_i,
   // Side inputs
   input  wire logic                 debug_req_i,
   input  wire trace_pkg::irq_t      irq_i,
   // Retirement record
   output logic                      valid_o,
   output trace_pkg::order_t         order_o,
   output trace_pkg::xlen_t          insn_o,
   output trace_pkg::xlen_t          pc_rdata_o,
   output trace_pkg::xlen_t          pc_wdata_o,
   output trace_pkg::trap_t          trap_o,
   output trace_pkg::reg_mask_t      rd_mask_o,
   output trace_pkg::xlen_t          rd_wdata_o,
   // Merged CSRs
   output trace_pkg::xlen_t          mstatus_value_o,
   output logic                      mstatus_wb_o,
   output trace_pkg::xlen_t          mepc_value_o,
   output logic                      mepc_wb_o,
   output trace_pkg::xlen_t          mcause_value_o,
   output logic                      mcause_wb_o,
   // Events
   output logic                      halt_o,
   output logic                      halt_push_o,
   output logic                      nmi_o,
   output trace_pkg::nmi_cause_t     nmi_cause_o,
   output logic                      nmi_push_o,
   output logic                      ifault_o,
   output logic                      ifault_push_o,
   output trace_pkg::irq_lines_t     irq_lines_o,
   output logic                      irq_push_o
);

   retire_capture i_retire (
      .rvvi(rvvi), .arst_n_i(arst_n_i), .rvfi_valid_i(rvfi_valid_i),
      .rvfi_order_i(rvfi_order_i), .rvfi_insn_i(rvfi_insn_i),
      .rvfi_pc_rdata_i(rvfi_pc_rdata_i), .rvfi_pc_wdata_i(rvfi_pc_wdata_i),
      .rvfi_trap_i(rvfi_trap_i), .rd_addr_i(rd_addr_i), .rd_wdata_i(rd_wdata_i),
      .valid_o(valid_o), .order_o(order_o), .insn_o(insn_o),
      .pc_rdata_o(pc_rdata_o), .pc_wdata_o(pc_wdata_o), .trap_o(trap_o),
      .rd_mask_o(rd_mask_o), .rd_wdata_o(rd_wdata_o)
   );

   ////////////////////////////////////////////////////////////////////////
   // CSR merges

   csr_merge i_mstatus (
      .rvvi(rvvi), .arst_n_i(arst_n_i), .rvfi_valid_i(rvfi_valid_i),
      .rdata_i(mstatus_rdata_i), .wdata_i(mstatus_wdata_i),
      .rmask_i(mstatus_rmask_i), .wmask_i(mstatus_wmask_i),
      .value_o(mstatus_value_o), .wb_o(mstatus_wb_o)
   );

   csr_merge i_mepc (
      .rvvi(rvvi), .arst_n_i(arst_n_i), .rvfi_valid_i(rvfi_valid_i),
      .rdata_i(mepc_rdata_i), .wdata_i(mepc_wdata_i),
      .rmask_i(mepc_rmask_i), .wmask_i(mepc_wmask_i),
      .value_o(mepc_value_o), .wb_o(mepc_wb_o)
   );

   csr_merge i_mcause (
      .rvvi(rvvi), .arst_n_i(arst_n_i), .rvfi_valid_i(rvfi_valid_i),
      .rdata_i(mcause_rdata_i), .wdata_i(mcause_wdata_i),
      .rmask_i(mcause_rmask_i), .wmask_i(mcause_wmask_i),
      .value_o(mcause_value_o), .wb_o(mcause_wb_o)
   );

   ////////////////////////////////////////////////////////////////////////
   // Event sources

   halt_stretch i_halt (
      .rvvi(rvvi), .arst_n_i(arst_n_i), .debug_req_i(debug_req_i),
      .halt_o(halt_o), .halt_push_o(halt_push_o)
   );

   nmi_fault_tracker i_nmi (
      .rvvi(rvvi), .arst_n_i(arst_n_i), .rvfi_valid_i(rvfi_valid_i),
      .rvfi_trap_i(rvfi_trap_i), .rvfi_nmip_i(rvfi_nmip_i),
      .nmi_o(nmi_o), .nmi_cause_o(nmi_cause_o), .nmi_push_o(nmi_push_o),
      .ifault_o(ifault_o), .ifault_push_o(ifault_push_o)
   );

   irq_sampler i_irq (
      .rvvi(rvvi), .arst_n_i(arst_n_i), .irq_i(irq_i),
      .irq_lines_o(irq_lines_o), .irq_push_o(irq_push_o)
   );

endmodule

`default_nettype wire

// File: tb/tb_rvfi_event_bridge.sv
/*
 * Directed testbench for the retirement trace event bridge
 * Record capture, CSR merge, halt stretch, NMI and fault, interrupt sampling
 */

`default_nettype none

module tb_rvfi_event_bridge;

   timeunit 1ns;
   timeprecision 1ps;

   logic                  rvvi;
   logic                  arst_n_i;
   logic                  rvfi_valid_i;
   trace_pkg::order_t     rvfi_order_i;
   trace_pkg::xlen_t      rvfi_insn_i;
   trace_pkg::trap_t      rvfi_trap_i;
   trace_pkg::xlen_t      rvfi_pc_rdata_i;
   trace_pkg::xlen_t      rvfi_pc_wdata_i;
   trace_pkg::nmip_t      rvfi_nmip_i;
   trace_pkg::reg_addr_t  rd_addr_i;
   trace_pkg::xlen_t      rd_wdata_i;
   trace_pkg::xlen_t      mstatus_rdata_i, mstatus_wdata_i, mstatus_rmask_i, mstatus_wmask_i;
   trace_pkg::xlen_t      mepc_rdata_i, mepc_wdata_i, mepc_rmask_i, mepc_wmask_i;
   trace_pkg::xlen_t      mcause_rdata_i, mcause_wdata_i, mcause_rmask_i, mcause_wmask_i;
   logic                  debug_req_i;
   trace_pkg::irq_t       irq_i;

   logic                  valid_o;
   trace_pkg::order_t     order_o;
   trace_pkg::xlen_t      insn_o, pc_rdata_o, pc_wdata_o, rd_wdata_o;
   trace_pkg::trap_t      trap_o;
   trace_pkg::reg_mask_t  rd_mask_o;
   trace_pkg::xlen_t      mstatus_value_o, mepc_value_o, mcause_value_o;
   logic                  mstatus_wb_o, mepc_wb_o, mcause_wb_o;
   logic                  halt_o, halt_push_o;
   logic                  nmi_o, nmi_push_o, ifault_o, ifault_push_o;
   trace_pkg::nmi_cause_t nmi_cause_o;
   trace_pkg::irq_lines_t irq_lines_o;
   logic                  irq_push_o;

   integer seed = 32'h6e8e_3f56;
   int     halt_pushes;
   int     nmi_pushes;
   int     ifault_pushes;
   int     irq_pushes;

   rvfi_event_bridge i_dut (.*);

   always #20 rvvi = ~rvvi;

   ////////////////////////////////////////////////////////////////////////
   // Failure and compare helpers

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_xlen(input string name, input trace_pkg::xlen_t got,
                             input trace_pkg::xlen_t exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_order(input string name, input trace_pkg::order_t got,
                              input trace_pkg::order_t exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_trap(input string name, input trace_pkg::trap_t got,
                             input trace_pkg::trap_t exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_mask(input string name, input trace_pkg::reg_mask_t got,
                             input trace_pkg::reg_mask_t exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_lines(input string name, input trace_pkg::irq_lines_t got,
                              input trace_pkg::irq_lines_t exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_cause(input string name, input trace_pkg::nmi_cause_t got,
                              input trace_pkg::nmi_cause_t exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   // One clock, then count the strobes seen in the new cycle
   task automatic tick();
      @(posedge rvvi);
      #2;
      if (halt_push_o) halt_pushes++;
      if (nmi_push_o) nmi_pushes++;
      if (ifault_push_o) ifault_pushes++;
      if (irq_push_o) irq_pushes++;
   endtask

   // Per bit: written bits first, then read bits, else zero
   function automatic trace_pkg::xlen_t expected_merge(input trace_pkg::xlen_t r,
      input trace_pkg::xlen_t w, input trace_pkg::xlen_t rm, input trace_pkg::xlen_t wm);
      trace_pkg::xlen_t res;
      for (int i = 0; i < 32; i++) begin
         if (wm[i]) res[i] = w[i];
         else if (rm[i]) res[i] = r[i];
         else res[i] = 1'b0;
      end
      return res;
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic outputs_zero_test();
      check_bit("valid_o", valid_o, 1'b0);
      check_order("order_o", order_o, '0);
      check_xlen("insn_o", insn_o, '0);
      check_xlen("pc_rdata_o", pc_rdata_o, '0);
      check_xlen("pc_wdata_o", pc_wdata_o, '0);
      check_trap("trap_o", trap_o, '0);
      check_mask("rd_mask_o", rd_mask_o, '0);
      check_xlen("rd_wdata_o", rd_wdata_o, '0);
      check_xlen("mstatus_value_o", mstatus_value_o, '0);
      check_xlen("mepc_value_o", mepc_value_o, '0);
      check_xlen("mcause_value_o", mcause_value_o, '0);
      check_bit("mstatus_wb_o", mstatus_wb_o, 1'b0);
      check_bit("mepc_wb_o", mepc_wb_o, 1'b0);
      check_bit("mcause_wb_o", mcause_wb_o, 1'b0);
      check_bit("halt_o", halt_o, 1'b0);
      check_bit("halt_push_o", halt_push_o, 1'b0);
      check_bit("nmi_o", nmi_o, 1'b0);
      check_cause("nmi_cause_o", nmi_cause_o, '0);
      check_bit("nmi_push_o", nmi_push_o, 1'b0);
      check_bit("ifault_o", ifault_o, 1'b0);
      check_bit("ifault_push_o", ifault_push_o, 1'b0);
      check_lines("irq_lines_o", irq_lines_o, '0);
      check_bit("irq_push_o", irq_push_o, 1'b0);
   endtask

   task automatic retire_record_test();
      trace_pkg::order_t order;
      trace_pkg::xlen_t  insn;
      trace_pkg::xlen_t  pc_r;
      trace_pkg::xlen_t  pc_w;
      trace_pkg::xlen_t  rd_data;
      trace_pkg::trap_t  trap;
      order   = {$random(seed), $random(seed)};
      insn    = $random(seed);
      pc_r    = $random(seed);
      pc_w    = $random(seed);
      rd_data = $random(seed);
      trap    = trace_pkg::trap_t'($random(seed));
      rvfi_valid_i    = 1'b1;
      rvfi_order_i    = order;
      rvfi_insn_i     = insn;
      rvfi_pc_rdata_i = pc_r;
      rvfi_pc_wdata_i = pc_w;
      rvfi_trap_i     = trap;
      rd_addr_i       = 5'd7;
      rd_wdata_i      = rd_data;
      tick();
      check_bit("valid_o", valid_o, 1'b1);
      check_order("order_o", order_o, order);
      check_xlen("insn_o", insn_o, insn);
      check_xlen("pc_rdata_o", pc_rdata_o, pc_r);
      check_xlen("pc_wdata_o", pc_wdata_o, pc_w);
      check_trap("trap_o", trap_o, trap);
      // x7 written
      check_mask("rd_mask_o", rd_mask_o, 32'h0000_0080);
      check_xlen("rd_wdata_o", rd_wdata_o, rd_data);
      rd_addr_i   = '0;
      rvfi_trap_i = '0;
      tick();
      check_mask("rd_mask_o", rd_mask_o, '0);
      check_trap("trap_o", trap_o, '0);
      rvfi_valid_i = 1'b0;
   endtask

   task automatic csr_merge_test();
      trace_pkg::xlen_t exp_mstatus;
      trace_pkg::xlen_t exp_mepc;
      trace_pkg::xlen_t exp;
      // Bit 0 always written as one, so every value moves away from zero
      mstatus_rdata_i = $random(seed);
      mstatus_wdata_i = $random(seed) | 32'h1;
      mstatus_rmask_i = $random(seed);
      mstatus_wmask_i = $random(seed) | 32'h1;
      mepc_rdata_i    = $random(seed);
      mepc_wdata_i    = $random(seed) | 32'h1;
      mepc_rmask_i    = $random(seed);
      mepc_wmask_i    = $random(seed) | 32'h1;
      mcause_rdata_i  = $random(seed);
      mcause_wdata_i  = $random(seed) | 32'h1;
      mcause_rmask_i  = $random(seed);
      mcause_wmask_i  = $random(seed) | 32'h1;
      exp_mstatus = expected_merge(mstatus_rdata_i, mstatus_wdata_i,
                                   mstatus_rmask_i, mstatus_wmask_i);
      exp_mepc    = expected_merge(mepc_rdata_i, mepc_wdata_i, mepc_rmask_i, mepc_wmask_i);
      exp = expected_merge(mcause_rdata_i, mcause_wdata_i, mcause_rmask_i, mcause_wmask_i);
      tick();
      check_xlen("mstatus_value_o", mstatus_value_o, exp_mstatus);
      check_bit("mstatus_wb_o", mstatus_wb_o, 1'b1);
      check_xlen("mepc_value_o", mepc_value_o, exp_mepc);
      check_bit("mepc_wb_o", mepc_wb_o, 1'b1);
      check_xlen("mcause_value_o", mcause_value_o, exp);
      check_bit("mcause_wb_o", mcause_wb_o, 1'b1);
      // Same observation again, now consumed by a retirement
      rvfi_valid_i = 1'b1;
      tick();
      check_xlen("mstatus_value_o", mstatus_value_o, exp_mstatus);
      check_bit("mstatus_wb_o", mstatus_wb_o, 1'b0);
      check_xlen("mepc_value_o", mepc_value_o, exp_mepc);
      check_bit("mepc_wb_o", mepc_wb_o, 1'b0);
      check_xlen("mcause_value_o", mcause_value_o, exp);
      check_bit("mcause_wb_o", mcause_wb_o, 1'b0);
      rvfi_valid_i = 1'b0;
   endtask

   task automatic halt_stretch_test();
      int n;
      halt_pushes = 0;
      debug_req_i = 1'b1;
      tick();
      check_bit("halt_o", halt_o, 1'b1);
      check_bit("halt_push_o", halt_push_o, 1'b1);
      tick();
      tick();
      debug_req_i = 1'b0;
      // First edge that sees the request low
      tick();
      check_bit("halt_o", halt_o, 1'b1);
      n = 0;
      while (halt_o) begin
         if (n == 20) abort_run("halt_o never fell after the debug request dropped");
         tick();
         n++;
      end
      if (n != 5) abort_run($sformatf("halt_o fell %0d cycles after the request, not 5", n));
      tick();
      if (halt_pushes != 2) abort_run("halt_push_o did not pulse exactly twice");
   endtask

   task automatic nmi_fault_test();
      trace_pkg::trap_t fault_trap;
      nmi_pushes    = 0;
      ifault_pushes = 0;
      // Trap, exception, cause 48 in bits 8:3
      fault_trap      = '0;
      fault_trap[0]   = 1'b1;
      fault_trap[1]   = 1'b1;
      fault_trap[8:3] = 6'd48;
      rvfi_valid_i = 1'b1;
      rvfi_nmip_i  = 2'b11;
      tick();
      check_bit("nmi_o", nmi_o, 1'b1);
      check_cause("nmi_cause_o", nmi_cause_o, 11'h401);
      check_bit("nmi_push_o", nmi_push_o, 1'b1);
      check_bit("ifault_o", ifault_o, 1'b0);
      rvfi_trap_i = fault_trap;
      tick();
      check_bit("ifault_o", ifault_o, 1'b1);
      check_bit("ifault_push_o", ifault_push_o, 1'b1);
      check_bit("nmi_o", nmi_o, 1'b1);
      // No retirement, so both levels hold
      rvfi_valid_i = 1'b0;
      rvfi_nmip_i  = '0;
      rvfi_trap_i  = '0;
      repeat (3) tick();
      check_bit("nmi_o", nmi_o, 1'b1);
      check_cause("nmi_cause_o", nmi_cause_o, 11'h401);
      check_bit("ifault_o", ifault_o, 1'b1);
      if (nmi_pushes != 1) abort_run("nmi_push_o did not pulse exactly once");
      if (ifault_pushes != 1) abort_run("ifault_push_o did not pulse exactly once");
   endtask

   task automatic irq_sample_test();
      int n;
      irq_pushes = 0;
      irq_i      = 32'h0010_0808;
      n = 0;
      while (!irq_push_o) begin
         if (n == 8) abort_run("irq_push_o never pulsed after the interrupt inputs changed");
         tick();
         n++;
      end
      // Software to bit 0, external to bit 2, local line 20 to bit 7
      check_lines("irq_lines_o", irq_lines_o, 19'h0_0085);
      repeat (4) tick();
      if (irq_pushes != 1) abort_run("irq_push_o pulsed again with steady interrupt inputs");
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Sequence

   initial begin
      rvvi            = 1'b0;
      arst_n_i        = 1'b0;
      rvfi_valid_i    = 1'b0;
      rvfi_order_i    = '0;
      rvfi_insn_i     = '0;
      rvfi_trap_i     = '0;
      rvfi_pc_rdata_i = '0;
      rvfi_pc_wdata_i = '0;
      rvfi_nmip_i     = '0;
      rd_addr_i       = '0;
      rd_wdata_i      = '0;
      mstatus_rdata_i = '0;
      mstatus_wdata_i = '0;
      mstatus_rmask_i = '0;
      mstatus_wmask_i = '0;
      mepc_rdata_i    = '0;
      mepc_wdata_i    = '0;
      mepc_rmask_i    = '0;
      mepc_wmask_i    = '0;
      mcause_rdata_i  = '0;
      mcause_wdata_i  = '0;
      mcause_rmask_i  = '0;
      mcause_wmask_i  = '0;
      debug_req_i     = 1'b0;
      irq_i           = '0;
      repeat (10) @(posedge rvvi);
      #2;
      arst_n_i = 1'b1;
      outputs_zero_test();
      retire_record_test();
      csr_merge_test();
      halt_stretch_test();
      nmi_fault_test();
      irq_sample_test();
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
logic/trace_pkg.sv
logic/csr_merge.sv
logic/retire_capture.sv
logic/halt_stretch.sv
logic/nmi_fault_tracker.sv
logic/irq_sampler.sv
logic/rvfi_event_bridge.sv
tb/tb_rvfi_event_bridge.sv
